// ==== Makefile ====
VERILATOR ?= verilator
FLAGS     ?= --binary --timing -j 0
TOP       ?= tb_bf_core
FILELIST  ?= tb.f
OBJ_DIR   ?= obj_dir
LOG       ?= sim.log

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(FLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR)

run: build
	./$(OBJ_DIR)/V$(TOP) | tee $(LOG)
	grep -q "test passed" $(LOG)

lint:
	$(VERILATOR) --lint-only --timing --top-module $(TOP) -f $(FILELIST)

clean:
	rm -rf $(OBJ_DIR) $(LOG)

// ==== rtl/bf_core.sv ====
/*
 * Top level of the tape engine.
 * Connects the FSM, program counter and tape store, forms the outgoing
 * serial word and provides the 2-bit inspection port.
 */

`timescale 1ns/100ps

module bf_core import bf_pkg::*; (
    input  logic              clk,
    input  logic              rst_n,
    input  logic [2:0]        instruction,
    input  logic              instr_valid,
    input  logic [1:0]        inspect_sel,
    output logic [data_w-1:0] inspect_data,
    output logic              interrupt_jump,
    output logic              interrupt_io,
    output logic              tx_start,
    output logic [xfer_w-1:0] tx_data,
    input  logic              tx_done,
    output logic              rx_enable,
    input  logic [xfer_w-1:0] rx_data,
    input  logic              rx_done
);

    tape_ctrl_t        tape_ctrl;
    pc_ctrl_t          pc_ctrl;
    logic              tx_sel_stack;
    logic              data_zero;
    logic [data_w-1:0] data_current;
    logic [ptr_w-1:0]  ptr;
    logic [pc_w-1:0]   pc;
    logic [pc_w-1:0]   stack_top;

    bf_fsm i_fsm (
        .clk            (clk),
        .rst_n          (rst_n),
        .instruction    (opcode_e'(instruction)),
        .instr_valid    (instr_valid),
        .data_zero      (data_zero),
        .tx_done        (tx_done),
        .rx_done        (rx_done),
        .tape_ctrl      (tape_ctrl),
        .pc_ctrl        (pc_ctrl),
        .interrupt_jump (interrupt_jump),
        .interrupt_io   (interrupt_io),
        .tx_start       (tx_start),
        .tx_sel_stack   (tx_sel_stack),
        .rx_enable      (rx_enable)
    );

    pc_counter i_pc (
        .clk       (clk),
        .rst_n     (rst_n),
        .pc_ctrl   (pc_ctrl),
        .rx_data   (rx_data),
        .pc        (pc),
        .stack_top (stack_top)
    );

    tape_store i_tape (
        .clk          (clk),
        .rst_n        (rst_n),
        .tape_ctrl    (tape_ctrl),
        .rx_data      (rx_data),
        .data_current (data_current),
        .ptr          (ptr),
        .data_zero    (data_zero)
    );

    // Stack top for a back jump, otherwise the cell zero-extended
    assign tx_data = tx_sel_stack ? stack_top : xfer_w'(data_current);

    always_comb begin
        case (inspect_sel)
            2'd0:    inspect_data = data_current;
            2'd1:    inspect_data = data_w'(ptr);
            2'd2:    inspect_data = pc[data_w-1:0];
            default: inspect_data = stack_top[data_w-1:0];
        endcase
    end

endmodule

// ==== rtl/bf_fsm.sv ====
/*
 * Control FSM of the tape engine.
 * Decodes one opcode per instr_valid strobe in st_exec and issues
 * single-cycle strobes to the tape and the program counter. Loop jumps
 * and byte I/O park the engine in a wait state, raise an interrupt
 * level and run the tx or rx exchange with the host.
 */

`timescale 1ns/100ps

module bf_fsm import bf_pkg::*; (
    input  logic       clk,
    input  logic       rst_n,
    input  opcode_e    instruction,
    input  logic       instr_valid,
    input  logic       data_zero,
    input  logic       tx_done,
    input  logic       rx_done,
    output tape_ctrl_t tape_ctrl,
    output pc_ctrl_t   pc_ctrl,
    output logic       interrupt_jump,
    output logic       interrupt_io,
    output logic       tx_start,
    output logic       tx_sel_stack,
    output logic       rx_enable
);

    state_e  state;
    opcode_e op_saved;   // Opcode that caused the current wait
    logic    go_jump;
    logic    go_io;
    logic    finish;     // Host exchange completes this cycle

    // Only a ']' sends from the jump wait, and it sends the stack top
    assign tx_sel_stack = (state == st_wait_jump);

    always_comb begin
        tape_ctrl = '0;
        pc_ctrl   = '0;
        go_jump   = 1'b0;
        go_io     = 1'b0;
        finish    = 1'b0;
        case (state)
            st_exec: begin
                if (instr_valid) begin
                    case (instruction)
                        op_minus: begin
                            tape_ctrl.dec = 1'b1;
                            pc_ctrl.step  = 1'b1;
                        end
                        op_plus: begin
                            tape_ctrl.inc = 1'b1;
                            pc_ctrl.step  = 1'b1;
                        end
                        op_left: begin
                            tape_ctrl.left = 1'b1;
                            pc_ctrl.step   = 1'b1;
                        end
                        op_right: begin
                            tape_ctrl.right = 1'b1;
                            pc_ctrl.step    = 1'b1;
                        end
                        op_open: begin
                            if (data_zero) begin
                                go_jump = 1'b1;       // Forward target unknown here
                            end else begin
                                pc_ctrl.push = 1'b1;  // Enter loop body
                                pc_ctrl.step = 1'b1;
                            end
                        end
                        op_close: begin
                            if (data_zero) begin
                                pc_ctrl.pop  = 1'b1;  // Leave loop
                                pc_ctrl.step = 1'b1;
                            end else begin
                                go_jump = 1'b1;
                            end
                        end
                        op_in, op_out: go_io = 1'b1;
                    endcase
                end
            end
            st_wait_jump: begin
                if (op_saved == op_close) begin
                    if (tx_done) begin
                        // Back to the matching '[' so it is evaluated again
                        pc_ctrl.pop         = 1'b1;
                        pc_ctrl.jump        = 1'b1;
                        pc_ctrl.jump_to_top = 1'b1;
                        finish              = 1'b1;
                    end
                end else if (rx_done) begin
                    pc_ctrl.push = 1'b1;  // Remember '[' address
                    pc_ctrl.jump = 1'b1;
                    finish       = 1'b1;
                end
            end
            st_wait_io: begin
                if (op_saved == op_out) begin
                    if (tx_done) begin
                        pc_ctrl.step = 1'b1;
                        finish       = 1'b1;
                    end
                end else if (rx_done) begin
                    tape_ctrl.load = 1'b1;
                    pc_ctrl.step   = 1'b1;
                    finish         = 1'b1;
                end
            end
            default: ;
        endcase
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state          <= st_exec;
            op_saved       <= op_minus;
            interrupt_jump <= 1'b0;
            interrupt_io   <= 1'b0;
            tx_start       <= 1'b0;
            rx_enable      <= 1'b0;
        end else begin
            if (go_jump || go_io) begin
                op_saved <= instruction;
                state    <= go_jump ? st_wait_jump : st_wait_io;
                // Exchange starts together with the interrupt level
                if (instruction == op_close || instruction == op_out) begin
                    tx_start <= 1'b1;
                end else begin
                    rx_enable <= 1'b1;
                end
                if (go_jump) begin
                    interrupt_jump <= 1'b1;
                end else begin
                    interrupt_io <= 1'b1;
                end
            end else if (finish) begin
                state          <= st_exec;
                interrupt_jump <= 1'b0;
                interrupt_io   <= 1'b0;
                tx_start       <= 1'b0;
                rx_enable      <= 1'b0;
            end
        end
    end

endmodule

// ==== rtl/bf_pkg.sv ====
/*
 * Shared widths, sizes, opcode and state encodings for the tape engine.
 * Holds the packed control structs that the FSM drives into the
 * program counter and the tape store. Imported by every RTL module.
 */

package bf_pkg;

    localparam int pc_w        = 10;  // Program address width
    localparam int data_w      = 8;   // Tape cell width
    localparam int xfer_w      = 10;  // Host serial word width
    localparam int tape_cells  = 16;
    localparam int ptr_w       = 4;
    localparam int stack_depth = 8;   // Loop bracket nesting limit
    localparam int stack_w     = 3;

    // Host opcode encoding
    typedef enum logic [2:0] {
        op_minus = 3'd0,
        op_plus  = 3'd1,
        op_left  = 3'd2,
        op_right = 3'd3,
        op_open  = 3'd4,
        op_close = 3'd5,
        op_in    = 3'd6,
        op_out   = 3'd7
    } opcode_e;

    typedef enum logic [1:0] {
        st_exec,
        st_wait_jump,  // Loop jump exchange with host
        st_wait_io     // Byte in or out exchange
    } state_e;

    // Single-cycle strobes into the tape
    typedef struct packed {
        logic inc;
        logic dec;
        logic left;
        logic right;
        logic load;   // Write host byte into current cell
    } tape_ctrl_t;

    // Single-cycle strobes into the program counter
    typedef struct packed {
        logic step;
        logic push;
        logic pop;
        logic jump;
        logic jump_to_top;  // Target is stack top, else host word
    } pc_ctrl_t;

endpackage

// ==== rtl/pc_counter.sv ====
/*
 * Program counter with the loop bracket return stack.
 * Applies step, push, pop and jump strobes from the FSM on one edge.
 * Jump targets come from the stack top or from the host word.
 */

`timescale 1ns/100ps

module pc_counter import bf_pkg::*; (
    input  logic              clk,
    input  logic              rst_n,
    input  pc_ctrl_t          pc_ctrl,
    input  logic [xfer_w-1:0] rx_data,
    output logic [pc_w-1:0]   pc,
    output logic [pc_w-1:0]   stack_top
);

    logic [pc_w-1:0]    stack [stack_depth];
    logic [stack_w-1:0] sp;   // Number of live entries
    logic [pc_w-1:0]    jump_target;

    assign stack_top = (sp == '0) ? '0 : stack[sp - 1'b1];

    assign jump_target = pc_ctrl.jump_to_top ? stack_top : rx_data[pc_w-1:0];

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            pc <= '0;
            sp <= '0;
        end else begin
            if (pc_ctrl.jump) begin
                pc <= jump_target;
            end else if (pc_ctrl.step) begin
                pc <= pc + 1'b1;
            end

            if (pc_ctrl.push) begin
                sp <= sp + 1'b1;
            end else if (pc_ctrl.pop) begin
                sp <= sp - 1'b1;
            end
        end
    end

    // Stack storage, valid only below sp
    always_ff @(posedge clk) begin
        if (pc_ctrl.push) begin
            stack[sp] <= pc;  // Address of the '[' itself
        end
    end

endmodule

// ==== rtl/tape_store.sv ====
/*
 * On-chip tape of tape_cells bytes with the data pointer.
 * Increment and decrement wrap modulo 256, pointer moves stop at both
 * ends. The current cell is read combinationally under the pointer.
 */

`timescale 1ns/100ps

module tape_store import bf_pkg::*; (
    input  logic              clk,
    input  logic              rst_n,
    input  tape_ctrl_t        tape_ctrl,
    input  logic [xfer_w-1:0] rx_data,
    output logic [data_w-1:0] data_current,
    output logic [ptr_w-1:0]  ptr,
    output logic              data_zero
);

    localparam logic [ptr_w-1:0] last_cell = ptr_w'(tape_cells - 1);

    logic [data_w-1:0] cells [tape_cells];

    assign data_current = cells[ptr];    // Follows pointer moves at once
    assign data_zero    = (data_current == '0);

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            ptr <= '0;
            for (int i = 0; i < tape_cells; i++) begin
                cells[i] <= '0;
            end
        end else begin
            if (tape_ctrl.inc) begin
                cells[ptr] <= data_current + 1'b1;
            end else if (tape_ctrl.dec) begin
                cells[ptr] <= data_current - 1'b1;
            end else if (tape_ctrl.load) begin
                cells[ptr] <= rx_data[data_w-1:0];  // Host byte, upper bits dropped
            end

            // Blocked moves leave the pointer where it is
            if (tape_ctrl.left && ptr != '0) begin
                ptr <= ptr - 1'b1;
            end else if (tape_ctrl.right && ptr != last_cell) begin
                ptr <= ptr + 1'b1;
            end
        end
    end

endmodule

// ==== tb.f ====
rtl/bf_pkg.sv
rtl/bf_fsm.sv
rtl/pc_counter.sv
rtl/tape_store.sv
rtl/bf_core.sv
testbench/tb_clock.sv
testbench/bf_checker.sv
testbench/tb_bf_core.sv

// ==== testbench/bf_checker.sv ====
/*
 * Watches the DUT ports and compares them with expected values.
 * Checks the interrupt and host strobe levels, captures tx_data on each
 * tx_start rise and steps inspect_sel through all four views when the
 * testbench top asks for a row check.
 */

`timescale 1ns/100ps

module bf_checker import bf_pkg::*; (
    input  logic              clk,
    input  logic              interrupt_jump,
    input  logic              interrupt_io,
    input  logic              tx_start,
    input  logic [xfer_w-1:0] tx_data,
    input  logic              rx_enable,
    input  logic [data_w-1:0] inspect_data,
    output logic [1:0]        inspect_sel
);

    int                errors = 0;
    int                tx_rises = 0;    // tx_start rises seen so far
    int                tx_checked = 0;  // Rises already matched to a row
    logic              tx_prev = 1'b0;
    logic [xfer_w-1:0] tx_word = '0;

    initial inspect_sel = 2'd0;

    // Sampled on the falling edge away from DUT updates
    always @(negedge clk) begin
        if (tx_start && !tx_prev) begin
            tx_rises <= tx_rises + 1;
            tx_word  <= tx_data;
        end
        tx_prev <= tx_start;
    end

    task automatic compare(input string name, input logic [xfer_w-1:0] exp,
                           input logic [xfer_w-1:0] act);
        if (exp !== act) begin
            $display("CHECK FAILED %s: expected %0h, actual %0h", name, exp, act);
            errors++;
        end
    endtask

    task automatic check_view(input string name, input logic [1:0] sel,
                              input logic [data_w-1:0] exp);
        inspect_sel = sel;
        #1;
        compare(name, xfer_w'(exp), xfer_w'(inspect_data));
    endtask

    // Interrupt levels and host strobes against their expected values
    task automatic check_levels(input string name, input logic exp_jump,
                                input logic exp_io, input logic exp_tx,
                                input logic exp_rx);
        compare($sformatf("%s interrupt_jump", name), xfer_w'(exp_jump),
                xfer_w'(interrupt_jump));
        compare($sformatf("%s interrupt_io", name), xfer_w'(exp_io),
                xfer_w'(interrupt_io));
        compare($sformatf("%s tx_start", name), xfer_w'(exp_tx), xfer_w'(tx_start));
        compare($sformatf("%s rx_enable", name), xfer_w'(exp_rx), xfer_w'(rx_enable));
    endtask

    task automatic check_idle();
        check_levels("reset", 1'b0, 1'b0, 1'b0, 1'b0);
        for (int s = 0; s < 4; s++) begin
            check_view($sformatf("reset view %0d", s), 2'(s), '0);
        end
    endtask

    task automatic check_row(input int row, input logic exp_send,
                             input logic [xfer_w-1:0] exp_tx,
                             input logic [data_w-1:0] exp_data,
                             input logic [data_w-1:0] exp_ptr,
                             input logic [data_w-1:0] exp_pc,
                             input logic [data_w-1:0] exp_top);
        if (exp_send && tx_rises == tx_checked) begin
            $display("Row %0d expected a send but tx_start never rose", row);
            errors++;
        end else if (!exp_send && tx_rises != tx_checked) begin
            $display("Row %0d sent a word that was not expected", row);
            errors++;
        end else if (exp_send) begin
            compare($sformatf("row %0d tx_data", row), exp_tx, tx_word);
        end
        tx_checked = tx_rises;
        check_view($sformatf("row %0d data", row), 2'd0, exp_data);
        check_view($sformatf("row %0d pointer", row), 2'd1, exp_ptr);
        check_view($sformatf("row %0d pc", row), 2'd2, exp_pc);
        check_view($sformatf("row %0d stack top", row), 2'd3, exp_top);
    endtask

endmodule

// ==== testbench/tb_bf_core.sv ====
/*
 * Testbench top for the tape engine.
 * Builds a stimulus table from a reference model of the opcode rules,
 * applies it row by row and plays the host for jump and I/O exchanges.
 */

`timescale 1ns/100ps

module tb_bf_core import bf_pkg::*; ();

    localparam int max_rows = 64;
    localparam int wait_limit = 50;

    logic              clk;
    logic              rst_n;
    logic [2:0]        instruction = 3'd0;
    logic              instr_valid = 1'b0;
    logic [1:0]        inspect_sel;
    logic [data_w-1:0] inspect_data;
    logic              interrupt_jump;
    logic              interrupt_io;
    logic              tx_start;
    logic [xfer_w-1:0] tx_data;
    logic              tx_done = 1'b0;
    logic              rx_enable;
    logic [xfer_w-1:0] rx_data = '0;
    logic              rx_done = 1'b0;

    // Stimulus table and expected results
    opcode_e           t_op [max_rows];
    logic [xfer_w-1:0] t_reply [max_rows];
    logic              t_jump [max_rows];  // Jump exchange expected
    logic              t_io [max_rows];    // Byte I/O exchange expected
    logic              t_send [max_rows];
    logic [xfer_w-1:0] t_tx [max_rows];
    logic [data_w-1:0] t_data [max_rows];
    logic [data_w-1:0] t_ptr [max_rows];
    logic [data_w-1:0] t_pc [max_rows];
    logic [data_w-1:0] t_top [max_rows];
    int                n_rows = 0;
    int                timeouts = 0;

    // Reference model state used while the table is built
    logic [data_w-1:0] m_cells [tape_cells];
    int                m_ptr = 0;
    logic [pc_w-1:0]   m_pc = '0;
    logic [pc_w-1:0]   m_stack [$];
    logic [31:0]       lfsr_state = 32'hdfa8;

    tb_clock i_clock (.clk(clk), .rst_n(rst_n));

    bf_core i_dut (
        .clk(clk), .rst_n(rst_n), .instruction(instruction), .instr_valid(instr_valid),
        .inspect_sel(inspect_sel), .inspect_data(inspect_data),
        .interrupt_jump(interrupt_jump), .interrupt_io(interrupt_io),
        .tx_start(tx_start), .tx_data(tx_data), .tx_done(tx_done),
        .rx_enable(rx_enable), .rx_data(rx_data), .rx_done(rx_done)
    );

    bf_checker i_chk (
        .clk(clk), .interrupt_jump(interrupt_jump), .interrupt_io(interrupt_io),
        .tx_start(tx_start), .tx_data(tx_data), .rx_enable(rx_enable),
        .inspect_data(inspect_data), .inspect_sel(inspect_sel)
    );

    // Fibonacci LFSR with taps 32 22 2 1
    function automatic logic [31:0] lfsr_next(input logic [31:0] s);
        return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
    endfunction

    task automatic random_byte(output logic [7:0] b);
        b = '0;
        for (int k = 0; k < 8; k++) begin
            lfsr_state = lfsr_next(lfsr_state);
            b = {b[6:0], lfsr_state[0]};
        end
    endtask

    // Appends one row and advances the reference model
    task automatic add_op(input opcode_e op, input logic [xfer_w-1:0] reply);
        logic [pc_w-1:0] top;
        logic [pc_w-1:0] next_pc;
        t_op[n_rows]    = op;
        t_reply[n_rows] = reply;
        t_jump[n_rows]  = 1'b0;
        t_io[n_rows]    = 1'b0;
        t_send[n_rows]  = 1'b0;
        t_tx[n_rows]    = '0;
        next_pc         = m_pc + 1'b1;  // Unless a jump is taken
        case (op)
            op_minus: m_cells[m_ptr]--;
            op_plus:  m_cells[m_ptr]++;
            op_left:  if (m_ptr > 0) m_ptr--;
            op_right: if (m_ptr < tape_cells - 1) m_ptr++;
            op_open: begin
                m_stack.push_back(m_pc);
                if (m_cells[m_ptr] == 0) begin
                    t_jump[n_rows] = 1'b1;
                    next_pc        = reply[pc_w-1:0];  // Forward target from the host
                end
            end
            op_close: begin
                top = m_stack.pop_back();
                if (m_cells[m_ptr] != 0) begin
                    t_jump[n_rows] = 1'b1;
                    t_send[n_rows] = 1'b1;  // Back jump target goes to the host
                    t_tx[n_rows]   = xfer_w'(top);
                    next_pc        = top;
                end
            end
            op_in: begin
                t_io[n_rows]   = 1'b1;
                m_cells[m_ptr] = reply[data_w-1:0];
            end
            op_out: begin
                t_io[n_rows]   = 1'b1;
                t_send[n_rows] = 1'b1;
                t_tx[n_rows]   = xfer_w'(m_cells[m_ptr]);
            end
        endcase
        m_pc           = next_pc;
        t_data[n_rows] = m_cells[m_ptr];
        t_ptr[n_rows]  = data_w'(m_ptr);
        t_pc[n_rows]   = m_pc[data_w-1:0];
        t_top[n_rows]  = (m_stack.size() == 0) ? '0 : m_stack[$][data_w-1:0];
        n_rows++;
    endtask

    task automatic build_table();
        logic [7:0] b;
        foreach (m_cells[i]) m_cells[i] = '0;
        add_op(op_minus, '0);      // Wrap 0 down to 255
        add_op(op_plus, '0);
        add_op(op_plus, '0);
        add_op(op_right, '0);
        add_op(op_plus, '0);
        add_op(op_plus, '0);
        add_op(op_left, '0);
        add_op(op_left, '0);       // Blocked at cell 0
        add_op(op_out, '0);
        random_byte(b);
        add_op(op_in, xfer_w'(b));
        add_op(op_out, '0);
        add_op(op_right, '0);
        add_op(op_left, '0);
        repeat (tape_cells) add_op(op_right, '0);  // Last one blocks
        add_op(op_plus, '0);
        add_op(op_left, '0);
        add_op(op_right, '0);
        add_op(op_open, '0);       // Nonzero cell enters the body
        add_op(op_close, '0);      // Nonzero cell jumps back
        add_op(op_open, '0);
        add_op(op_minus, '0);
        add_op(op_close, '0);      // Zero cell leaves the loop
        add_op(op_open, 10'h2a5);  // Zero cell takes the host target
    endtask

    task automatic serve_host(input int row, input logic [xfer_w-1:0] reply);
        int cnt;
        logic sending;
        cnt = 0;
        while (!(tx_start || rx_enable) && cnt < wait_limit) begin
            @(posedge clk);
            #1;
            cnt++;
        end
        if (cnt >= wait_limit) begin
            $display("Timed out waiting for tx_start or rx_enable");
            timeouts++;
        end
        sending = tx_start;
        rx_data = reply;
        if (sending) tx_done = 1'b1;
        else rx_done = 1'b1;
        @(posedge clk);
        #1;
        tx_done = 1'b0;
        rx_done = 1'b0;
        // Everything drops on the done edge
        i_chk.check_levels($sformatf("row %0d done", row), 1'b0, 1'b0, 1'b0, 1'b0);
        cnt = 0;
        while ((interrupt_jump || interrupt_io) && cnt < wait_limit) begin
            @(posedge clk);
            #1;
            cnt++;
        end
        if (cnt >= wait_limit) begin
            $display("Timed out waiting for the interrupt to drop");
            timeouts++;
        end
    endtask

    initial begin
        int cnt;
        build_table();
        cnt = 0;
        while (!rst_n && cnt < wait_limit) begin
            @(posedge clk);
            cnt++;
        end
        if (cnt >= wait_limit) begin
            $display("Timed out waiting for reset release");
            timeouts++;
        end
        @(posedge clk);
        #1 i_chk.check_idle();
        for (int i = 0; i < n_rows; i++) begin
            @(posedge clk);
            #1;
            instruction = t_op[i];
            instr_valid = 1'b1;
            @(posedge clk);
            #1;
            instr_valid = 1'b0;
            i_chk.check_levels($sformatf("row %0d strobe", i), t_jump[i], t_io[i],
                               t_send[i], (t_jump[i] || t_io[i]) && !t_send[i]);
            if (t_jump[i] || t_io[i]) serve_host(i, t_reply[i]);
            i_chk.check_row(i, t_send[i], t_tx[i], t_data[i], t_ptr[i], t_pc[i],
                            t_top[i]);
        end
        $display("Errors: %0d check, %0d timeout", i_chk.errors, timeouts);
        if (i_chk.errors == 0 && timeouts == 0) begin
            $display("test passed");
        end else begin
            $display("test failed");
        end
        $finish;
    end

endmodule

// ==== testbench/tb_clock.sv ====
/*
 * Clock and reset source for the testbench.
 * 8 ns clock, rst_n held low for the first two rising edges.
 */

`timescale 1ns/100ps

module tb_clock (
    output logic clk,
    output logic rst_n
);

    initial begin
        clk   = 1'b0;
        rst_n = 1'b0;
        repeat (2) @(posedge clk);
        #1 rst_n = 1'b1;  // Release away from the edge
    end

    always #4 clk = ~clk;

endmodule
